//--- cache_aq.f
+incdir+.
cache_aq_pkg.sv
access_queue.sv
aq_arbiter.sv
cache_aq_sys.sv
cache_aq_assertions.sv
cache_aq_tb.sv

//--- Bender.yml
package:
  name: cache_aq

sources:
  - include_dirs:
      - .
    files:
      - cache_aq_pkg.sv
      - access_queue.sv
      - aq_arbiter.sv
      - cache_aq_sys.sv
  - target: test
    include_dirs:
      - .
    files:
      - cache_aq_assertions.sv
      - cache_aq_tb.sv

//--- cache_aq_tb.sv
`timescale 1ns/1ps
`include "cache_aq_params.svh"

module cache_aq_tb
    import cache_aq_pkg::*;
();

    localparam int entry_w = $bits(aq_entry_t);

    logic      clk, rst_n_i, ptc_clr_i, read_i;
    aq_entry_t rd_req_i, sw_req_i, wb_req_i, req_o;
    logic      rd_write_i, sw_write_i, wb_write_i;
    logic      bus_valid_e_i, bus_valid_o_i, bus_pcd_i, bus_isempty_i;
    paddr_t    bus_paddr_e_i, bus_paddr_o_i;
    line_t     bus_data_e_i, bus_data_o_i;
    logic      valid_e_o, valid_o_o, from_bus_o, w_o, sw_o, r_o;
    logic      aq_isempty_o, rdaq_isfull_o, swaq_isfull_o, wbaq_isfull_o;

    aq_entry_t wb_q[$], rd_q[$], sw_q[$];   // Reference queues
    logic [31:0] lcg_state = 32'd3;

    cache_aq_sys uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [entry_w-1:0] exp,
                             input logic [entry_w-1:0] act);
        if (exp !== act) begin
            stop_fail($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Any assertion failure ends the run at once
    always @(negedge clk) begin
        if (uut.u_sva.fail_count != 0) begin
            stop_fail("an assertion in the bound checker failed");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic aq_entry_t rand_entry();
        logic [575:0] bits;
        for (int i = 0; i < 18; i++) begin
            bits[i*32 +: 32] = lcg_next();
        end
        return bits[entry_w-1:0];
    endfunction

    // Field clearing applied by the front end per source
    function automatic aq_entry_t expect_entry(input int which, input aq_entry_t e);
        aq_entry_t r;
        r = e;
        if (which == 0) begin
            r.qslot = '0;
        end else begin
            r.data_e = '0;
            r.data_o = '0;
            r.mask_e = '0;
            r.mask_o = '0;
        end
        return r;
    endfunction

    // which: 0 wb, 1 rd, 2 sw
    task automatic write_entry(input int which, input aq_entry_t e);
        @(posedge clk);
        case (which)
            0: begin
                wb_req_i   <= e;
                wb_write_i <= 1'b1;
            end
            1: begin
                rd_req_i   <= e;
                rd_write_i <= 1'b1;
            end
            default: begin
                sw_req_i   <= e;
                sw_write_i <= 1'b1;
            end
        endcase
        if (which == 0 && wb_q.size() < `CAQ_DEPTH) wb_q.push_back(expect_entry(0, e));
        if (which == 1 && rd_q.size() < `CAQ_DEPTH) rd_q.push_back(expect_entry(1, e));
        if (which == 2 && sw_q.size() < `CAQ_DEPTH) sw_q.push_back(expect_entry(2, e));
        @(posedge clk);
        wb_write_i <= 1'b0;
        rd_write_i <= 1'b0;
        sw_write_i <= 1'b0;
    endtask

    task automatic pop_check(input string name);
        aq_entry_t exp;
        int src;
        int t;
        logic ok;
        src = (wb_q.size() != 0) ? 0 : (rd_q.size() != 0) ? 1 : 2;
        t = 0;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = (src == 0) ? (w_o && !from_bus_o) : (src == 1) ? r_o : sw_o;
            t++;
            if (!ok && t > 20) stop_fail($sformatf("%s: source flag never raised", name));
        end
        exp = (src == 0) ? wb_q.pop_front() : (src == 1) ? rd_q.pop_front() : sw_q.pop_front();
        check_val(name, exp, req_o);
        check_val({name, " valids"}, {exp.valid_e, exp.valid_o}, {valid_e_o, valid_o_o});
        @(posedge clk);
        read_i <= 1'b1;
        @(posedge clk);
        read_i <= 1'b0;
    endtask

    task automatic drain(input string name);
        int t;
        t = 0;
        while (wb_q.size() + rd_q.size() + sw_q.size() != 0) begin
            pop_check(name);
            t++;
            if (t > 64) stop_fail($sformatf("%s: drain did not finish", name));
        end
        @(negedge clk);
        check_val({name, " empty"}, 1'b1, aq_isempty_o);
    endtask

    initial begin
        rst_n_i = 1'b0;
        ptc_clr_i = 1'b0;
        read_i = 1'b0;
        rd_req_i = '0;
        sw_req_i = '0;
        wb_req_i = '0;
        rd_write_i = 1'b0;
        sw_write_i = 1'b0;
        wb_write_i = 1'b0;
        bus_valid_e_i = 1'b0;
        bus_valid_o_i = 1'b0;
        bus_pcd_i = 1'b0;
        bus_isempty_i = 1'b1;
        bus_paddr_e_i = '0;
        bus_paddr_o_i = '0;
        bus_data_e_i = '0;
        bus_data_o_i = '0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        @(negedge clk);
        check_val("reset isempty", 1'b1, aq_isempty_o);
        check_val("reset valids", 2'b00, {valid_e_o, valid_o_o});
        check_val("reset full", 3'b000, {rdaq_isfull_o, swaq_isfull_o, wbaq_isfull_o});

        // FIFO order with interleaved writes
        for (int i = 0; i < 5; i++) begin
            write_entry(i % 3, rand_entry());
            write_entry((i + 1) % 3, rand_entry());
        end
        drain("fifo_order");

        // Bus fill over pending queues, read_i leaves queues alone
        write_entry(0, rand_entry());
        write_entry(1, rand_entry());
        write_entry(2, rand_entry());
        @(posedge clk);
        bus_paddr_e_i <= paddr_t'(lcg_next());
        bus_paddr_o_i <= paddr_t'(lcg_next());
        bus_valid_e_i <= 1'b1;
        bus_isempty_i <= 1'b0;
        @(posedge clk);
        read_i <= 1'b1;
        @(posedge clk);
        read_i <= 1'b0;
        @(negedge clk);
        check_val("bus paddr", bus_paddr_e_i, req_o.paddr_e);
        check_val("bus flags", 2'b11, {from_bus_o, w_o});
        @(posedge clk);
        bus_isempty_i <= 1'b1;
        bus_valid_e_i <= 1'b0;
        drain("bus_priority");

        // Full queues drop the ninth write
        for (int q = 0; q < 3; q++) begin
            for (int i = 0; i < 9; i++) begin
                write_entry(q, rand_entry());
            end
        end
        @(negedge clk);
        check_val("full flags", 3'b111, {rdaq_isfull_o, swaq_isfull_o, wbaq_isfull_o});
        drain("full_drop");

        // Protection clear keeps writebacks only
        for (int i = 0; i < 3; i++) begin
            write_entry(0, rand_entry());
            write_entry(1, rand_entry());
            write_entry(2, rand_entry());
        end
        @(posedge clk);
        ptc_clr_i <= 1'b1;
        @(posedge clk);
        ptc_clr_i <= 1'b0;
        rd_q.delete();
        sw_q.delete();
        @(negedge clk);
        check_val("ptc r sw", 2'b00, {r_o, sw_o});
        drain("ptc_clear");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- cache_aq_assertions.sv
`timescale 1ns/1ps

module cache_aq_assertions
    import cache_aq_pkg::*;
(
    input logic   clk,
    input logic   rst_n_i,
    input logic   ptc_clr_i,
    input logic   aq_isempty_o,
    input logic   valid_e_o,
    input logic   valid_o_o,
    input logic   bus_isempty_i,
    input paddr_t bus_paddr_e_i,
    input paddr_t req_paddr_e,
    input logic   from_bus_o,
    input logic   w_o,
    input logic   r_o,
    input logic   sw_o,
    input logic   wb_empty,
    input logic   rd_empty,
    input logic   sw_empty,
    input logic   rd_write_i,
    input logic   rd_pop,
    input logic   rdaq_isfull_o
);

    int fail_count = 0;   // Failed property count

    a_idle_outputs: assert property (@(posedge clk) disable iff (!rst_n_i)
        aq_isempty_o |-> (!valid_e_o && !valid_o_o && !w_o && !r_o && !sw_o))
        else begin
            fail_count++;
            $error("output raised while all sources empty");
        end

    a_bus_first: assert property (@(posedge clk) disable iff (!rst_n_i)
        !bus_isempty_i |-> (from_bus_o && w_o && !r_o && !sw_o
                            && req_paddr_e == bus_paddr_e_i))
        else begin
            fail_count++;
            $error("bus fill not selected first");
        end

    a_wb_next: assert property (@(posedge clk) disable iff (!rst_n_i)
        (bus_isempty_i && !wb_empty) |-> (w_o && !from_bus_o && !r_o && !sw_o))
        else begin
            fail_count++;
            $error("writeback not selected over loads");
        end

    a_rd_next: assert property (@(posedge clk) disable iff (!rst_n_i)
        (bus_isempty_i && wb_empty && !rd_empty) |-> (r_o && !w_o && !sw_o))
        else begin
            fail_count++;
            $error("load not selected over stores");
        end

    a_sw_last: assert property (@(posedge clk) disable iff (!rst_n_i)
        (bus_isempty_i && wb_empty && rd_empty && !sw_empty) |-> (sw_o && !w_o && !r_o))
        else begin
            fail_count++;
            $error("store not selected when it is the only pending source");
        end

    // Dropped ninth write keeps the queue full
    a_full_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rdaq_isfull_o && rd_write_i && !rd_pop && !ptc_clr_i) |=> rdaq_isfull_o)
        else begin
            fail_count++;
            $error("load queue left full state on write");
        end

endmodule

bind cache_aq_sys cache_aq_assertions u_sva (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ptc_clr_i     (ptc_clr_i),
    .aq_isempty_o  (aq_isempty_o),
    .valid_e_o     (valid_e_o),
    .valid_o_o     (valid_o_o),
    .bus_isempty_i (bus_isempty_i),
    .bus_paddr_e_i (bus_paddr_e_i),
    .req_paddr_e   (req_o.paddr_e),
    .from_bus_o    (from_bus_o),
    .w_o           (w_o),
    .r_o           (r_o),
    .sw_o          (sw_o),
    .wb_empty      (wb_empty),
    .rd_empty      (rd_empty),
    .sw_empty      (sw_empty),
    .rd_write_i    (rd_write_i),
    .rd_pop        (rd_pop),
    .rdaq_isfull_o (rdaq_isfull_o)
);

//--- cache_aq_sys.sv
`timescale 1ns/1ps
`include "cache_aq_params.svh"

module cache_aq_sys
    import cache_aq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      ptc_clr_i,
    input  aq_entry_t rd_req_i,
    input  aq_entry_t sw_req_i,
    input  aq_entry_t wb_req_i,
    input  logic      rd_write_i,
    input  logic      sw_write_i,
    input  logic      wb_write_i,
    input  logic      bus_valid_e_i,
    input  logic      bus_valid_o_i,
    input  paddr_t    bus_paddr_e_i,
    input  paddr_t    bus_paddr_o_i,
    input  line_t     bus_data_e_i,
    input  line_t     bus_data_o_i,
    input  logic      bus_pcd_i,
    input  logic      bus_isempty_i,
    input  logic      read_i,
    output aq_entry_t req_o,
    output logic      valid_e_o,
    output logic      valid_o_o,
    output logic      from_bus_o,
    output logic      w_o,
    output logic      sw_o,
    output logic      r_o,
    output logic      aq_isempty_o,
    output logic      rdaq_isfull_o,
    output logic      swaq_isfull_o,
    output logic      wbaq_isfull_o
);

    aq_entry_t rd_entry, sw_entry, wb_entry, bus_entry;
    aq_entry_t rd_head, sw_head, wb_head;
    aq_entry_t arb_entry;
    aq_src_e   arb_src;

    logic rdsw_flush, wb_flush;
    logic rd_empty, sw_empty, wb_empty;
    logic rd_pop, sw_pop, wb_pop;
    logic arb_sw;

    // Protection table clear drops loads and stores, writebacks survive
    assign rdsw_flush = ~rst_n_i | ptc_clr_i;
    assign wb_flush   = ~rst_n_i;

    // Loads and stores carry no data or mask into the queue
    always_comb begin
        rd_entry        = rd_req_i;
        rd_entry.data_e = '0;
        rd_entry.data_o = '0;
        rd_entry.mask_e = '0;
        rd_entry.mask_o = '0;
        sw_entry        = sw_req_i;
        sw_entry.data_e = '0;
        sw_entry.data_o = '0;
        sw_entry.mask_e = '0;
        sw_entry.mask_o = '0;
        wb_entry        = wb_req_i;
        wb_entry.qslot  = '0;     // No reorder slot for writebacks
    end

    always_comb begin
        bus_entry         = '0;
        bus_entry.valid_e = bus_valid_e_i;
        bus_entry.valid_o = bus_valid_o_i;
        bus_entry.paddr_e = bus_paddr_e_i;
        bus_entry.paddr_o = bus_paddr_o_i;
        bus_entry.data_e  = bus_data_e_i;
        bus_entry.data_o  = bus_data_o_i;
        bus_entry.mask_e  = `CAQ_BUS_MASK;
        bus_entry.mask_o  = `CAQ_BUS_MASK;
        bus_entry.pcd     = bus_pcd_i;
    end

    access_queue u_rdaq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (rdsw_flush),
        .write_i (rd_write_i),
        .entry_i (rd_entry),
        .pop_i   (rd_pop),
        .head_o  (rd_head),
        .empty_o (rd_empty),
        .full_o  (rdaq_isfull_o)
    );

    access_queue u_swaq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (rdsw_flush),
        .write_i (sw_write_i),
        .entry_i (sw_entry),
        .pop_i   (sw_pop),
        .head_o  (sw_head),
        .empty_o (sw_empty),
        .full_o  (swaq_isfull_o)
    );

    access_queue u_wbaq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (wb_flush),
        .write_i (wb_write_i),
        .entry_i (wb_entry),
        .pop_i   (wb_pop),
        .head_o  (wb_head),
        .empty_o (wb_empty),
        .full_o  (wbaq_isfull_o)
    );

    aq_arbiter u_arb (
        .bus_entry_i (bus_entry),
        .wb_head_i   (wb_head),
        .rd_head_i   (rd_head),
        .sw_head_i   (sw_head),
        .bus_empty_i (bus_isempty_i),
        .wb_empty_i  (wb_empty),
        .rd_empty_i  (rd_empty),
        .sw_empty_i  (sw_empty),
        .read_i      (read_i),
        .sel_entry_o (arb_entry),
        .src_o       (arb_src),
        .from_bus_o  (from_bus_o),
        .w_o         (w_o),
        .sw_o        (arb_sw),
        .r_o         (r_o),
        .wb_pop_o    (wb_pop),
        .rd_pop_o    (rd_pop),
        .sw_pop_o    (sw_pop)
    );

    assign aq_isempty_o = bus_isempty_i & wb_empty & rd_empty & sw_empty;

    assign req_o     = arb_entry;
    assign valid_e_o = arb_entry.valid_e & ~aq_isempty_o;
    assign valid_o_o = arb_entry.valid_o & ~aq_isempty_o;

    // Hide the idle store fallthrough
    assign sw_o = arb_sw & (arb_src != SRC_NONE);

endmodule

//--- aq_arbiter.sv
`timescale 1ns/1ps

module aq_arbiter
    import cache_aq_pkg::*;
(
    input  aq_entry_t bus_entry_i,
    input  aq_entry_t wb_head_i,
    input  aq_entry_t rd_head_i,
    input  aq_entry_t sw_head_i,
    input  logic      bus_empty_i,
    input  logic      wb_empty_i,
    input  logic      rd_empty_i,
    input  logic      sw_empty_i,
    input  logic      read_i,
    output aq_entry_t sel_entry_o,
    output aq_src_e   src_o,
    output logic      from_bus_o,
    output logic      w_o,
    output logic      sw_o,
    output logic      r_o,
    output logic      wb_pop_o,
    output logic      rd_pop_o,
    output logic      sw_pop_o
);

    // Bus fill, then writeback, then load, then store-write
    always_comb begin
        if (!bus_empty_i) begin
            src_o = SRC_BUS;
        end else if (!wb_empty_i) begin
            src_o = SRC_WB;
        end else if (!rd_empty_i) begin
            src_o = SRC_RD;
        end else if (!sw_empty_i) begin
            src_o = SRC_SW;
        end else begin
            src_o = SRC_NONE;
        end
    end

    always_comb begin
        sel_entry_o = sw_head_i;
        from_bus_o  = 1'b0;
        w_o         = 1'b0;
        sw_o        = 1'b0;
        r_o         = 1'b0;
        case (src_o)
            SRC_BUS: begin
                sel_entry_o = bus_entry_i;
                from_bus_o  = 1'b1;
                w_o         = 1'b1;       // Fill writes the array
            end
            SRC_WB: begin
                sel_entry_o = wb_head_i;
                w_o         = 1'b1;
            end
            SRC_RD: begin
                sel_entry_o = rd_head_i;
                r_o         = 1'b1;
            end
            SRC_SW: begin
                sel_entry_o = sw_head_i;
                sw_o        = 1'b1;
            end
            default: begin
                // Idle falls through to the store queue head
                sel_entry_o = sw_head_i;
                sw_o        = 1'b1;
            end
        endcase
    end

    // Bus is drained by its owner, never popped here
    assign wb_pop_o = read_i & (src_o == SRC_WB);
    assign rd_pop_o = read_i & (src_o == SRC_RD);
    assign sw_pop_o = read_i & (src_o == SRC_SW);

endmodule

//--- access_queue.sv
`timescale 1ns/1ps
`include "cache_aq_params.svh"

module access_queue
    import cache_aq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      write_i,
    input  aq_entry_t entry_i,
    input  logic      pop_i,
    output aq_entry_t head_o,
    output logic      empty_o,
    output logic      full_o
);

    aq_entry_t mem [`CAQ_DEPTH];

    logic [`CAQ_PTR_W-1:0] wr_ptr;
    logic [`CAQ_PTR_W-1:0] rd_ptr;
    logic [`CAQ_PTR_W:0]   count;

    logic do_write;
    logic do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == (`CAQ_PTR_W+1)'(`CAQ_DEPTH));

    // Flush beats a write in the same cycle
    assign do_write = write_i & ~full_o & ~flush_i;
    assign do_pop   = pop_i & ~empty_o;

    assign head_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            count <= '0;
        end else begin
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

endmodule

//--- cache_aq_pkg.sv
`include "cache_aq_params.svh"

package cache_aq_pkg;

    typedef logic [`CAQ_ADDR_W-1:0] paddr_t;      // Bank line address
    typedef logic [`CAQ_LINE_W-1:0] line_t;       // Data or byte mask half
    typedef logic [1:0]             acc_size_t;   // Access size code
    typedef logic [6:0]             ptcid_t;      // Protection table id
    typedef logic [7:0]             qslot_t;      // Reorder slot tag
    typedef logic [2:0]             onesize_t;    // Byte count in one bank

    // One pending cache access, even and odd bank halves side by side
    typedef struct packed {
        logic      valid_e;
        logic      valid_o;
        paddr_t    paddr_e;
        paddr_t    paddr_o;
        line_t     data_e;
        line_t     data_o;
        acc_size_t size_e;
        acc_size_t size_o;
        line_t     mask_e;
        line_t     mask_o;
        ptcid_t    ptcid;
        qslot_t    qslot;
        logic      odd_is_greater;
        logic      need_p1;         // Access spans into the next line
        onesize_t  onesize;
        logic      pcd;             // Page cache disable
    } aq_entry_t;

    // Source shown to the cache pipeline
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_BUS,
        SRC_WB,
        SRC_RD,
        SRC_SW
    } aq_src_e;

endpackage

//--- cache_aq_params.svh
`ifndef CACHE_AQ_PARAMS_SVH
`define CACHE_AQ_PARAMS_SVH

// Physical line address of one bank
`define CAQ_ADDR_W 15

// One data or mask half, 16 bytes
`define CAQ_LINE_W 128

// Entries held by each access queue
`define CAQ_DEPTH 8

// Queue pointer width, depth must stay a power of two
`define CAQ_PTR_W 3

// Bus fills write every byte of both halves
`define CAQ_BUS_MASK {`CAQ_LINE_W{1'b1}}

`endif
